// File: sim.f
hdl/rv_mem_pkg.sv
hdl/wb_bus_if.sv
hdl/lsu_align.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/mem_subsystem.sv
verification/mem_subsystem_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mem_subsystem_tb
FILELIST  = sim.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir

// File: verification/mem_subsystem_tb.sv
`timescale 1ns/10ps

module mem_subsystem_tb;
    import rv_mem_pkg::*;

    localparam int n_instr    = 127;
    localparam int ram_bytes  = ram_depth_words * 4;

    typedef struct packed {
        logic        we;
        reg_addr_t   addr;
        word_t       data;
        logic        mem;
        logic        timed;     // fixed latency applies without back-pressure.
        logic [31:0] acc;
    } item_t;

    logic      me_clk = 1'b0;
    logic      me_rst;
    logic      in_ce;
    opcode_t   in_opcode;
    funct3_t   in_funct3;
    addr_t     in_alu_value;
    word_t     in_rs2_data;
    reg_addr_t in_rd_addr;
    logic      in_stall;
    logic      in_flush;
    logic      out_ce;
    logic      out_rd_we;
    reg_addr_t out_rd_addr;
    word_t     out_rd_data;
    logic      out_stall;

    logic [7:0]  shadow [ram_bytes];   // reference copy of the ram.
    item_t       exp_q [$];
    item_t       head;
    logic        head_valid = 1'b0;
    logic [31:0] cyc_no = '0;
    int          errors = 0;
    word_t       rnd;

    mem_subsystem u_mem_subsystem (.*);

    always #2 me_clk = ~me_clk;

    always @(posedge me_clk) cyc_no <= cyc_no + 1;

    // retire the head when downstream takes it.
    always @(posedge me_clk) begin
        if (me_rst && out_ce && !in_stall && exp_q.size() != 0)
            void'(exp_q.pop_front());
    end

    always @(negedge me_clk) begin
        head_valid <= (exp_q.size() != 0);
        if (exp_q.size() != 0)
            head <= exp_q[0];
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_reset: assert property (@(posedge me_clk) !me_rst |-> !out_ce && !out_rd_we && !out_stall)
        else begin $display("outputs active during reset"); errors++; end

    a_expected: assert property (@(posedge me_clk) disable iff (!me_rst) out_ce |-> head_valid)
        else begin $display("out_ce with no instruction pending"); errors++; end

    a_we: assert property (@(posedge me_clk) disable iff (!me_rst)
        out_ce && head_valid |-> out_rd_we == head.we)
        else begin
            $display("Error out_rd_we got %h expected %h", out_rd_we, head.we);
            errors++;
        end

    a_addr: assert property (@(posedge me_clk) disable iff (!me_rst)
        out_ce && head_valid && head.we |-> out_rd_addr == head.addr)
        else begin
            $display("Error out_rd_addr got %h expected %h", out_rd_addr, head.addr);
            errors++;
        end

    a_data: assert property (@(posedge me_clk) disable iff (!me_rst)
        out_ce && head_valid && head.we |-> out_rd_data == head.data)
        else begin
            $display("Error out_rd_data got %h expected %h", out_rd_data, head.data);
            errors++;
        end

    // fixed latency from acceptance with upstream stalled during a bus access.
    a_latency: assert property (@(posedge me_clk) disable iff (!me_rst)
        out_ce && head_valid && head.timed |->
            cyc_no == head.acc + (head.mem ? 32'd4 : 32'd1)
            && (!head.mem || ($past(out_stall, 1) && $past(out_stall, 2)
            && $past(out_stall, 3))))
        else begin $display("result latency or out_stall wrong"); errors++; end

    a_hold: assert property (@(posedge me_clk) disable iff (!me_rst)
        out_ce && in_stall && !in_flush |=>
            out_ce && $stable(out_rd_data) && $stable(out_rd_addr))
        else begin $display("outputs changed under downstream stall"); errors++; end

    // ----------------------------------------
    // reference model and stimulus
    // ----------------------------------------
    function automatic word_t model_word(input logic [9:0] a);
        logic [9:0] w;
        w = {a[9:2], 2'b00};
        return {shadow[w + 3], shadow[w + 2], shadow[w + 1], shadow[w]};
    endfunction

    function automatic word_t model_load(input funct3_t f3, input logic [9:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[{a[9:1], 1'b1}], shadow[{a[9:1], 1'b0}]};
        case (f3)
            f3_b:    return {{24{b[7]}}, b};
            f3_bu:   return {24'h0, b};
            f3_h:    return {{16{h[15]}}, h};
            f3_hu:   return {16'h0, h};
            default: return model_word(a);
        endcase
    endfunction

    task automatic model_store(input funct3_t f3, input logic [9:0] a, input word_t d);
        case (f3)
            f3_b: shadow[a] = d[7:0];
            f3_h: begin
                shadow[{a[9:1], 1'b0}] = d[7:0];
                shadow[{a[9:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++)
                    shadow[{a[9:2], 2'b00} + i] = d[8*i +: 8];
            end
        endcase
    endtask

    // waits for a free slot and then presents one instruction for one cycle.
    task automatic issue(input opcode_t op, input funct3_t f3, input addr_t alu,
                         input word_t rs2, input reg_addr_t rd, input bit timed,
                         input bit keep);
        item_t it;
        while (out_stall) begin
            @(posedge me_clk);
            #0.5;
        end
        in_ce        = 1'b1;
        in_opcode    = op;
        in_funct3    = f3;
        in_alu_value = alu;
        in_rs2_data  = rs2;
        in_rd_addr   = rd;
        it.we    = (op != op_store);
        it.addr  = rd;
        it.mem   = (op == op_load) || (op == op_store);
        it.timed = timed;
        it.acc   = cyc_no;
        it.data  = alu;
        if (op == op_store) begin
            model_store(f3, alu[9:0], rs2);
            it.data = '0;
        end else if (op == op_load) begin
            it.data = model_load(f3, alu[9:0]);
        end
        if (keep)
            exp_q.push_back(it);
        @(posedge me_clk);
        #0.5;
        in_ce = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h15dc));
        for (int i = 0; i < ram_bytes; i++)
            shadow[i] = 8'h00;
        me_rst       = 1'b0;
        in_ce        = 1'b0;
        in_opcode    = op_itype;
        in_funct3    = f3_w;
        in_alu_value = '0;
        in_rs2_data  = '0;
        in_rd_addr   = '0;
        in_stall     = 1'b0;
        in_flush     = 1'b0;
        repeat (2) @(posedge me_clk);
        #0.5;
        me_rst = 1'b1;
        @(posedge me_clk);
        #0.5;

        // alu results pass straight through.
        issue(op_rtype, f3_w, 32'h1234_5678, '0, 5'd1, 1'b1, 1'b1);
        issue(op_itype, f3_w, 32'hdead_beef, '0, 5'd2, 1'b1, 1'b1);
        issue(op_lui,   f3_w, 32'hfff0_0000, '0, 5'd3, 1'b1, 1'b1);
        issue(op_jal,   f3_w, 32'h0000_0104, '0, 5'd4, 1'b1, 1'b1);

        issue(op_store, f3_w, 32'h0000_0040, 32'ha5a5_5a5a, 5'd0, 1'b1, 1'b1);
        issue(op_load,  f3_w, 32'h0000_0040, '0, 5'd5, 1'b1, 1'b1);

        // narrow stores followed by a check of the whole word.
        for (int off = 0; off < 4; off++) begin
            issue(op_store, f3_b, 32'h40 + off, 32'h0000_0011 * (off + 1), 5'd0, 1'b1, 1'b1);
            issue(op_load,  f3_w, 32'h40, '0, 5'd6, 1'b1, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(op_store, f3_h, 32'h80 + off, 32'h0000_c3d4 + off, 5'd0, 1'b1, 1'b1);
            issue(op_load,  f3_w, 32'h80, '0, 5'd7, 1'b1, 1'b1);
        end

        // ----------------------------------------
        // narrow loads over random words
        // ----------------------------------------
        for (int i = 0; i < 8; i++) begin
            addr_t a;
            a   = {22'h0, 8'($urandom % ram_depth_words), 2'b00};
            rnd = $urandom | 32'h8080_8080;   // bit 7 and 15 set.
            issue(op_store, f3_w, a, rnd, 5'd0, 1'b1, 1'b1);
            for (int off = 0; off < 4; off++) begin
                issue(op_load, f3_b,  a + off, '0, reg_addr_t'(8 + off), 1'b1, 1'b1);
                issue(op_load, f3_bu, a + off, '0, reg_addr_t'(12 + off), 1'b1, 1'b1);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(op_load, f3_h,  a + off, '0, reg_addr_t'(16 + off), 1'b1, 1'b1);
                issue(op_load, f3_hu, a + off, '0, reg_addr_t'(20 + off), 1'b1, 1'b1);
            end
        end

        // downstream stall on a presented result and on a pending load.
        issue(op_auipc, f3_w, 32'h0000_2000, '0, 5'd24, 1'b0, 1'b1);
        in_stall = 1'b1;
        repeat (3) @(posedge me_clk);
        #0.5;
        in_stall = 1'b0;
        issue(op_load, f3_w, 32'h40, '0, 5'd25, 1'b0, 1'b1);
        in_stall = 1'b1;
        repeat (6) @(posedge me_clk);
        #0.5;
        in_stall = 1'b0;

        // flushed store still lands in memory.
        issue(op_store, f3_w, 32'h0000_0100, 32'h0bad_f00d, 5'd0, 1'b0, 1'b0);
        in_flush = 1'b1;
        @(posedge me_clk);
        #0.5;
        in_flush = 1'b0;
        issue(op_load, f3_w, 32'h0000_0100, '0, 5'd26, 1'b1, 1'b0);
        in_flush = 1'b1;
        @(posedge me_clk);
        #0.5;
        in_flush = 1'b0;
        issue(op_load, f3_w, 32'h0000_0100, '0, 5'd27, 1'b1, 1'b1);

        while (exp_q.size() != 0 || out_stall || out_ce)
            @(posedge me_clk);
        repeat (4) @(posedge me_clk);
        $display("checks done, %0d errors, %0d results pending", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        repeat (n_instr * 8 + 200) @(posedge me_clk);
        $display("timeout, the run did not reach its end");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: hdl/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                  me_clk,
    input  logic                  me_rst,

    // from execute.
    input  logic                  in_ce,
    input  rv_mem_pkg::opcode_t   in_opcode,
    input  rv_mem_pkg::funct3_t   in_funct3,
    input  rv_mem_pkg::addr_t     in_alu_value,
    input  rv_mem_pkg::word_t     in_rs2_data,
    input  rv_mem_pkg::reg_addr_t in_rd_addr,
    input  logic                  in_stall,
    input  logic                  in_flush,

    // to write-back.
    output logic                  out_ce,
    output logic                  out_rd_we,
    output rv_mem_pkg::reg_addr_t out_rd_addr,
    output rv_mem_pkg::word_t     out_rd_data,
    output logic                  out_stall
);

    wb_bus_if u_wb ();

    // ----------------------------------------
    // pipeline stage
    // ----------------------------------------
    mem_stage u_mem_stage (
        .me_clk       (me_clk),
        .me_rst       (me_rst),
        .in_ce        (in_ce),
        .in_opcode    (in_opcode),
        .in_funct3    (in_funct3),
        .in_alu_value (in_alu_value),
        .in_rs2_data  (in_rs2_data),
        .in_rd_addr   (in_rd_addr),
        .in_stall     (in_stall),
        .in_flush     (in_flush),
        .wb           (u_wb.master),
        .out_ce       (out_ce),
        .out_rd_we    (out_rd_we),
        .out_rd_addr  (out_rd_addr),
        .out_rd_data  (out_rd_data),
        .out_stall    (out_stall)
    );

    // ----------------------------------------
    // data memory
    // ----------------------------------------
    data_ram #(
        .depth_words (rv_mem_pkg::ram_depth_words)
    ) u_data_ram (
        .me_clk (me_clk),
        .me_rst (me_rst),
        .wb     (u_wb.slave)
    );

endmodule

// File: hdl/data_ram.sv
`timescale 1ns/10ps

module data_ram #(
    parameter int depth_words = rv_mem_pkg::ram_depth_words
) (
    input logic     me_clk,
    input logic     me_rst,
    wb_bus_if.slave wb
);
    import rv_mem_pkg::*;

    localparam int idx_w = (depth_words > 1) ? $clog2(depth_words) : 1;
    localparam int cnt_w = $clog2(ram_wait_states + 1);

    word_t            mem [depth_words] = '{default: '0};
    logic [idx_w-1:0] word_idx;
    logic [cnt_w-1:0] wait_cnt;
    logic             hit;        // strobed and not yet acknowledged.
    logic             last_wait;

    assign word_idx  = wb.adr[idx_w-1:0];
    assign hit       = wb.cyc && wb.stb && !wb.ack;
    assign last_wait = (wait_cnt == cnt_w'(ram_wait_states - 1));

    // ----------------------------------------
    // wait states and ack
    // ----------------------------------------
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            wb.ack   <= 1'b0;
            wait_cnt <= '0;
        end else begin
            wb.ack <= hit && last_wait;   // single cycle pulse.
            if (hit && !last_wait)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;
        end
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge me_clk) begin
        if (hit && last_wait) begin
            if (wb.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (wb.sel[i])
                        mem[word_idx][8*i +: 8] <= wb.dat_w[8*i +: 8];
                end
            end
            wb.dat_r <= mem[word_idx];  // old contents on a write.
        end
    end

    a_ack_stb: assert property (@(posedge me_clk) disable iff (!me_rst)
        wb.ack |-> wb.stb)
        else $error("ack without stb");

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                  me_clk,
    input  logic                  me_rst,
    input  logic                  in_ce,
    input  rv_mem_pkg::opcode_t   in_opcode,
    input  rv_mem_pkg::funct3_t   in_funct3,
    input  rv_mem_pkg::addr_t     in_alu_value,
    input  rv_mem_pkg::word_t     in_rs2_data,
    input  rv_mem_pkg::reg_addr_t in_rd_addr,
    input  logic                  in_stall,
    input  logic                  in_flush,
    wb_bus_if.master              wb,
    output logic                  out_ce,
    output logic                  out_rd_we,
    output rv_mem_pkg::reg_addr_t out_rd_addr,
    output rv_mem_pkg::word_t     out_rd_data,
    output logic                  out_stall
);
    import rv_mem_pkg::*;

    stage_state_t state;

    // request captured at acceptance.
    funct3_t    req_funct3;
    logic [1:0] req_offset;
    reg_addr_t  req_rd_addr;
    logic       req_load;
    logic       req_kill;     // flushed while on the bus.

    // response parked while downstream is stalled.
    logic       rsp_done;
    word_t      rsp_data;

    funct3_t    align_funct3;
    logic [1:0] align_offset;
    word_t      lane_wdata;
    sel_t       lane_sel;
    word_t      load_value;
    word_t      result_data;

    logic is_mem;
    logic writes_rd;
    logic accept;
    logic result_ready;
    logic finish;
    logic deliver;

    assign is_mem    = (in_opcode == op_load) || (in_opcode == op_store);
    assign writes_rd = in_opcode inside {op_rtype, op_itype, op_jal, op_jalr, op_lui, op_auipc};

    assign out_stall    = in_stall || (state == st_wait_ack);
    assign accept       = in_ce && !out_stall && !in_flush;
    assign result_ready = (state == st_wait_ack) && (wb.ack || rsp_done);
    assign finish       = result_ready && (req_kill || in_flush || !in_stall);
    assign deliver      = result_ready && !req_kill && !in_flush && !in_stall;
    assign result_data  = rsp_done ? rsp_data : load_value;

    // one aligner, store side when idle and load side while waiting.
    assign align_funct3 = (state == st_idle) ? in_funct3 : req_funct3;
    assign align_offset = (state == st_idle) ? in_alu_value[1:0] : req_offset;

    lsu_align u_lsu_align (
        .funct3      (align_funct3),
        .byte_offset (align_offset),
        .store_data  (in_rs2_data),
        .bus_rdata   (wb.dat_r),
        .bus_wdata   (lane_wdata),
        .bus_sel     (lane_sel),
        .load_value  (load_value)
    );

    // ----------------------------------------
    // issue fsm and bus control
    // ----------------------------------------
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            state    <= st_idle;
            wb.cyc   <= 1'b0;
            wb.stb   <= 1'b0;
            wb.we    <= 1'b0;
            req_kill <= 1'b0;
            rsp_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && is_mem) begin
                        state    <= st_wait_ack;
                        wb.cyc   <= 1'b1;
                        wb.stb   <= 1'b1;
                        wb.we    <= (in_opcode == op_store);
                        req_kill <= 1'b0;
                    end
                end
                st_wait_ack: begin
                    if (wb.ack) begin   // cycle ends, drop the strobe.
                        wb.cyc <= 1'b0;
                        wb.stb <= 1'b0;
                        wb.we  <= 1'b0;
                    end
                    if (in_flush)
                        req_kill <= 1'b1;
                    if (finish) begin
                        state    <= st_idle;
                        rsp_done <= 1'b0;
                    end else if (wb.ack) begin
                        rsp_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge me_clk) begin
        if ((state == st_idle) && accept && is_mem) begin
            wb.adr      <= {2'b00, in_alu_value[31:2]};
            wb.dat_w    <= lane_wdata;
            wb.sel      <= (in_opcode == op_store) ? lane_sel : 4'b1111;
            req_funct3  <= in_funct3;
            req_offset  <= in_alu_value[1:0];
            req_rd_addr <= in_rd_addr;
            req_load    <= (in_opcode == op_load);
        end
        if (wb.ack)
            rsp_data <= load_value;
    end

    // ----------------------------------------
    // write-back registers
    // ----------------------------------------
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            out_ce    <= 1'b0;
            out_rd_we <= 1'b0;
        end else if (in_flush) begin
            out_ce    <= 1'b0;
            out_rd_we <= 1'b0;
        end else if (!in_stall) begin
            if (deliver) begin
                out_ce    <= 1'b1;
                out_rd_we <= req_load;  // stores retire without a write.
            end else if (accept && !is_mem) begin
                out_ce    <= 1'b1;
                out_rd_we <= writes_rd;
            end else begin
                out_ce    <= 1'b0;
                out_rd_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge me_clk) begin
        if (deliver) begin
            out_rd_addr <= req_rd_addr;
            out_rd_data <= result_data;
        end else if (accept && !is_mem) begin
            out_rd_addr <= in_rd_addr;
            out_rd_data <= in_alu_value;
        end
    end

    a_stb_cyc: assert property (@(posedge me_clk) disable iff (!me_rst)
        wb.stb |-> wb.cyc)
        else $error("stb high without cyc");

    a_bus_stable: assert property (@(posedge me_clk) disable iff (!me_rst)
        wb.stb && !wb.ack |=> $stable(wb.adr) && $stable(wb.sel))
        else $error("adr or sel changed before ack");

    a_idle_stall: assert property (@(posedge me_clk) disable iff (!me_rst)
        (state == st_idle) && out_stall |-> in_stall)
        else $error("upstream stalled while idle");

endmodule

// File: hdl/lsu_align.sv
`timescale 1ns/10ps

module lsu_align (
    input  rv_mem_pkg::funct3_t funct3,
    input  logic [1:0]          byte_offset,
    input  rv_mem_pkg::word_t   store_data,
    input  rv_mem_pkg::word_t   bus_rdata,
    output rv_mem_pkg::word_t   bus_wdata,
    output rv_mem_pkg::sel_t    bus_sel,
    output rv_mem_pkg::word_t   load_value
);
    import rv_mem_pkg::*;

    logic [1:0] lane;      // offset after alignment masking.
    word_t      shifted;

    // misaligned halves and words fall back to the aligned lane.
    always_comb begin
        case (funct3)
            f3_b, f3_bu: lane = byte_offset;
            f3_h, f3_hu: lane = {byte_offset[1], 1'b0};
            default:     lane = 2'b00;
        endcase
    end

    // ----------------------------------------
    // store path
    // ----------------------------------------
    always_comb begin
        case (funct3)
            f3_b: begin
                bus_wdata = {4{store_data[7:0]}};
                bus_sel   = 4'b0001 << lane;
            end
            f3_h: begin
                bus_wdata = {2{store_data[15:0]}};
                bus_sel   = 4'b0011 << lane;
            end
            default: begin
                bus_wdata = store_data;
                bus_sel   = 4'b1111;
            end
        endcase
    end

    // ----------------------------------------
    // load path
    // ----------------------------------------
    assign shifted = bus_rdata >> {lane, 3'b000};

    always_comb begin
        case (funct3)
            f3_b:    load_value = {{24{shifted[7]}}, shifted[7:0]};
            f3_h:    load_value = {{16{shifted[15]}}, shifted[15:0]};
            f3_bu:   load_value = {24'h000000, shifted[7:0]};
            f3_hu:   load_value = {16'h0000, shifted[15:0]};
            default: load_value = shifted;
        endcase
    end

endmodule

// File: hdl/wb_bus_if.sv
`timescale 1ns/10ps

interface wb_bus_if;
    import rv_mem_pkg::*;

    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;     // word address.
    word_t dat_w;
    sel_t  sel;
    word_t dat_r;
    logic  ack;

    // the stage side.
    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

// File: hdl/rv_mem_pkg.sv
package rv_mem_pkg;

    // ----------------------------------------
    // data widths
    // ----------------------------------------
    typedef logic [31:0] word_t;      // data word.
    typedef logic [31:0] addr_t;      // byte address from the alu.
    typedef logic [4:0]  reg_addr_t;  // register index.
    typedef logic [3:0]  sel_t;       // byte lane mask.

    // ----------------------------------------
    // instruction fields
    // ----------------------------------------
    // rv32i major opcodes seen by this stage.
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_rtype = 7'b0110011,
        op_itype = 7'b0010011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_t;

    // access size, stores use b, h and w only.
    typedef enum logic [2:0] {
        f3_b  = 3'b000,
        f3_h  = 3'b001,
        f3_w  = 3'b010,
        f3_bu = 3'b100,
        f3_hu = 3'b101
    } funct3_t;

    // ----------------------------------------
    // stage control and ram timing
    // ----------------------------------------
    typedef enum logic {
        st_idle,
        st_wait_ack
    } stage_state_t;

    localparam int ram_wait_states = 2;    // cycles of held stb before ack.
    localparam int ram_depth_words = 256;

endpackage
